/* hw/hash_cu_defs.svh */
`ifndef HASH_CU_DEFS_SVH
`define HASH_CU_DEFS_SVH

// Bus widths
`define HCU_OP_W        8
`define HCU_XFER_W      16
`define HCU_MSG_W       32
`define HCU_HOP_W       5

// Read opcode, checked before the indexed commands
`define HCU_CMD_READ    8'h80

// Command index in opcode bits 3..0, valid when bits 7..5 are zero
`define HCU_IDX_CLEAR   4'd0
`define HCU_IDX_S0_INIT 4'd1
`define HCU_IDX_S0_RECV 4'd2
`define HCU_IDX_S0_FINL 4'd3
`define HCU_IDX_S1_CERT 4'd4

// Hash opcode is {mode, sha384, phase}
`define HCU_MODE_S0     2'b10
`define HCU_MODE_S1     2'b00
`define HCU_PH_INIT     2'd0
`define HCU_PH_UPDATE   2'd1
`define HCU_PH_FINAL    2'd2

// Response codes; size and parameter errors share one code
`define HCU_ERR_NONE    2'd0
`define HCU_ERR_CMD     2'd1
`define HCU_ERR_SIZE    2'd2
`define HCU_ERR_PRM     2'd2

// Largest read length in bytes
`define HCU_RD_MAX      16'd48

`endif

/* hw/hash_cu_pkg.sv */
`default_nettype none

`include "hash_cu_defs.svh"

package hash_cu_pkg;

   // L3 command fields
   typedef logic [`HCU_OP_W-1:0]   cmd_op_t;
   typedef logic [3:0]             cmd_idx_t;
   typedef logic [`HCU_XFER_W-1:0] xfer_size_t;

   // Running message length handed to the hash engine
   typedef logic [`HCU_MSG_W-1:0]  msg_size_t;

   typedef logic [`HCU_HOP_W-1:0]  hash_op_t;

   // Response code, also used for the checker verdict
   typedef logic [1:0]             resp_err_t;

endpackage

`default_nettype wire

/* hw/session_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface session_if;
   // Single-cycle strobes from the sequencer
   logic s0_set;
   logic s0_clr;
   logic s1_set;
   logic s1_clr;
   logic size0_clr;
   logic size0_add;
   logic size1_load;
   logic size1_clr;

   // Session state
   logic                   s0_vld;
   logic                   s1_vld;
   logic                   s0_384;
   logic                   s1_384;
   hash_cu_pkg::msg_size_t size0;
   hash_cu_pkg::msg_size_t size1;

   modport seq (
      output s0_set, s0_clr, s1_set, s1_clr, size0_clr, size0_add, size1_load, size1_clr,
      input  s0_384, s1_384, size0, size1
   );

   modport regs (
      input  s0_set, s0_clr, s1_set, s1_clr, size0_clr, size0_add, size1_load, size1_clr,
      output s0_vld, s1_vld, s0_384, s1_384, size0, size1
   );

   modport chk (
      input s0_vld, s1_vld
   );
endinterface

`default_nettype wire

/* hw/cmd_check.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hash_cu_defs.svh"

module cmd_check (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     cmd_take,
   input  hash_cu_pkg::cmd_op_t    cmd_op,
   input  hash_cu_pkg::xfer_size_t cmd_extend,
   input  hash_cu_pkg::xfer_size_t wr_size,
   session_if.chk                  sess,
   output hash_cu_pkg::cmd_idx_t   cmd_idx,
   output logic                    cmd_384,
   output logic                    cmd_is_read,
   output hash_cu_pkg::xfer_size_t cmd_wr_size,
   output hash_cu_pkg::resp_err_t  verdict
);

   hash_cu_pkg::cmd_op_t    op_q;
   hash_cu_pkg::xfer_size_t ext_q;
   hash_cu_pkg::xfer_size_t size_q;
   logic                    s0_busy_chk;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         op_q <= '0;
      end else if (cmd_take) begin
         op_q <= cmd_op;
      end
   end

   // Transfer lengths
   always_ff @(posedge clk) begin
      if (cmd_take) begin
         ext_q  <= cmd_extend;
         size_q <= wr_size;
      end
   end

   assign cmd_idx     = op_q[3:0];
   assign cmd_384     = op_q[4];
   assign cmd_is_read = (op_q == `HCU_CMD_READ);
   assign cmd_wr_size = size_q;

   // S0 data commands need S0 open and S1 idle
   assign s0_busy_chk = !sess.s0_vld || sess.s1_vld;

   always_comb begin
      verdict = `HCU_ERR_NONE;
      if (cmd_is_read) begin
         if ((size_q != '0) || (ext_q == '0) || (ext_q > `HCU_RD_MAX)) begin
            verdict = `HCU_ERR_SIZE;
         end
      end else if (op_q[7:5] != 3'd0) begin
         verdict = `HCU_ERR_CMD;
      end else begin
         case (op_q[3:0])
            `HCU_IDX_CLEAR: verdict = `HCU_ERR_NONE;
            `HCU_IDX_S0_INIT: begin
               // S1 has priority over a new S0
               if (sess.s1_vld) begin
                  verdict = `HCU_ERR_PRM;
               end else if (size_q != '0) begin
                  verdict = `HCU_ERR_SIZE;
               end
            end
            `HCU_IDX_S0_RECV: begin
               if (s0_busy_chk) begin
                  verdict = `HCU_ERR_PRM;
               end else if (size_q == '0) begin
                  verdict = `HCU_ERR_SIZE;
               end
            end
            `HCU_IDX_S0_FINL: begin
               if (s0_busy_chk) begin
                  verdict = `HCU_ERR_PRM;
               end else if (size_q != '0) begin
                  verdict = `HCU_ERR_SIZE;
               end
            end
            `HCU_IDX_S1_CERT: begin
               if (sess.s1_vld) begin
                  verdict = `HCU_ERR_PRM;
               end
            end
            default: verdict = `HCU_ERR_CMD;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/session_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module session_regs (
   input  wire                     clk,
   input  wire                     rst_n,
   session_if.regs                 sess,
   input  hash_cu_pkg::xfer_size_t cmd_wr_size,
   input  wire                     cmd_384
);

   // S0 session flags, 384 mode latched at init
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sess.s0_vld <= 1'b0;
         sess.s0_384 <= 1'b0;
      end else if (sess.s0_clr) begin
         sess.s0_vld <= 1'b0;
      end else if (sess.s0_set) begin
         sess.s0_vld <= 1'b1;
         sess.s0_384 <= cmd_384;
      end
   end

   // S1 session flags
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sess.s1_vld <= 1'b0;
         sess.s1_384 <= 1'b0;
      end else if (sess.s1_clr) begin
         sess.s1_vld <= 1'b0;
      end else if (sess.s1_set) begin
         sess.s1_vld <= 1'b1;
         sess.s1_384 <= cmd_384;
      end
   end

   // Total bytes received on S0
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sess.size0 <= '0;
      end else if (sess.size0_clr) begin
         sess.size0 <= '0;
      end else if (sess.size0_add) begin
         sess.size0 <= sess.size0 + hash_cu_pkg::msg_size_t'(cmd_wr_size);
      end
   end

   // Certificate length, loaded once per S1 command
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sess.size1 <= '0;
      end else if (sess.size1_clr) begin
         sess.size1 <= '0;
      end else if (sess.size1_load) begin
         sess.size1 <= hash_cu_pkg::msg_size_t'(cmd_wr_size);
      end
   end

endmodule

`default_nettype wire

/* hw/hash_seq_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hash_cu_defs.svh"

module hash_seq_fsm (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     clr_hash,
   input  wire                     ss_expire,
   input  wire                     cmd_en,
   input  hash_cu_pkg::cmd_idx_t   cmd_idx,
   input  wire                     cmd_384,
   input  wire                     cmd_is_read,
   input  hash_cu_pkg::resp_err_t  verdict,
   input  wire                     hash_update,
   input  wire                     msg_update,
   input  wire                     h_buf_rdy,
   input  wire                     m_buf_rdy,
   input  wire                     hash_rdy,
   input  wire                     hash_done,
   session_if.seq                  sess,
   output logic                    cmd_take,
   output logic                    cmd_rdy,
   output logic                    wr_open,
   output logic                    rd_open,
   output logic                    resp_done,
   output hash_cu_pkg::resp_err_t  resp_err,
   output logic                    rcv_clr,
   output logic                    hash_finish,
   output logic                    h_buf_clr,
   output logic                    h_buf_en,
   output logic                    h_buf_wrm,
   output logic                    m_buf_en,
   output logic                    m_buf_clr,
   output hash_cu_pkg::hash_op_t   hash_op,
   output logic                    hash_en,
   output logic                    hash_clr,
   output hash_cu_pkg::msg_size_t  msg_size
);

   typedef enum logic [3:0] {
      IDLE,
      EXEC,
      RESP_ERR,
      CLEAR,
      S0_HASH_WRD,
      S0_HASH_FIN,
      S1_HASH_CERT,
      S1_HASH_FINAL,
      DONE
   } state_t;

   state_t state;
   state_t state_nxt;

   // Forced clear wins over any state
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
      end else if (clr_hash || ss_expire) begin
         state <= CLEAR;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt       = state;
      cmd_take        = 1'b0;
      cmd_rdy         = 1'b0;
      wr_open         = 1'b0;
      rd_open         = 1'b0;
      resp_done       = 1'b0;
      resp_err        = `HCU_ERR_NONE;
      rcv_clr         = 1'b0;
      hash_finish     = 1'b0;
      h_buf_clr       = 1'b0;
      h_buf_en        = 1'b0;
      h_buf_wrm       = 1'b0;
      m_buf_en        = 1'b0;
      m_buf_clr       = 1'b0;
      hash_op         = '0;
      hash_en         = 1'b0;
      hash_clr        = 1'b0;
      msg_size        = '0;
      sess.s0_set     = 1'b0;
      sess.s0_clr     = 1'b0;
      sess.s1_set     = 1'b0;
      sess.s1_clr     = 1'b0;
      sess.size0_clr  = 1'b0;
      sess.size0_add  = 1'b0;
      sess.size1_load = 1'b0;
      sess.size1_clr  = 1'b0;

      case (state)
         IDLE: begin
            cmd_rdy  = 1'b1;
            cmd_take = cmd_en;
            if (cmd_en) begin
               state_nxt = EXEC;
            end
         end
         EXEC: begin
            if (verdict != `HCU_ERR_NONE) begin
               state_nxt = RESP_ERR;
            end else if (cmd_is_read) begin
               // Read has no response of its own
               rd_open   = 1'b1;
               state_nxt = IDLE;
            end else begin
               case (cmd_idx)
                  `HCU_IDX_S0_INIT: begin
                     h_buf_clr      = 1'b1;
                     sess.s0_set    = 1'b1;
                     sess.size0_clr = 1'b1;
                     hash_op        = {`HCU_MODE_S0, cmd_384, `HCU_PH_INIT};
                     hash_en        = 1'b1;
                     state_nxt      = S0_HASH_WRD;
                  end
                  `HCU_IDX_S0_RECV: begin
                     // Write data goes to the header buffer
                     sess.size0_add = 1'b1;
                     h_buf_en       = 1'b1;
                     wr_open        = 1'b1;
                     state_nxt      = S0_HASH_WRD;
                  end
                  `HCU_IDX_S0_FINL: begin
                     hash_finish = 1'b1;
                     state_nxt   = S0_HASH_FIN;
                  end
                  `HCU_IDX_S1_CERT: begin
                     sess.s1_set     = 1'b1;
                     sess.size1_load = 1'b1;
                     wr_open         = 1'b1;
                     m_buf_en        = 1'b1;
                     hash_op         = {`HCU_MODE_S1, cmd_384, `HCU_PH_INIT};
                     hash_en         = 1'b1;
                     state_nxt       = S1_HASH_CERT;
                  end
                  // Clear command
                  default: state_nxt = CLEAR;
               endcase
            end
         end
         RESP_ERR: begin
            rcv_clr   = 1'b1;
            resp_done = 1'b1;
            resp_err  = verdict;
            state_nxt = IDLE;
         end
         CLEAR: begin
            resp_done      = 1'b1;
            rcv_clr        = 1'b1;
            hash_clr       = 1'b1;
            h_buf_clr      = 1'b1;
            m_buf_clr      = 1'b1;
            sess.s0_clr    = 1'b1;
            sess.s1_clr    = 1'b1;
            sess.size0_clr = 1'b1;
            sess.size1_clr = 1'b1;
            state_nxt      = IDLE;
         end
         S0_HASH_WRD: begin
            hash_op   = {`HCU_MODE_S0, sess.s0_384, `HCU_PH_UPDATE};
            // Engine writes back the intermediate digest
            h_buf_wrm = hash_done;
            if (hash_update) begin
               hash_en = 1'b1;
            end else if (h_buf_rdy && hash_rdy) begin
               state_nxt = DONE;
            end
         end
         S0_HASH_FIN: begin
            hash_op  = {`HCU_MODE_S0, sess.s0_384, `HCU_PH_FINAL};
            msg_size = sess.size0;
            if (hash_rdy) begin
               hash_en   = 1'b1;
               state_nxt = DONE;
            end
         end
         S1_HASH_CERT: begin
            hash_op = {`HCU_MODE_S1, sess.s1_384, `HCU_PH_UPDATE};
            if (msg_update) begin
               hash_en = 1'b1;
            end else if (m_buf_rdy && hash_rdy) begin
               state_nxt = S1_HASH_FINAL;
            end
         end
         S1_HASH_FINAL: begin
            hash_op  = {`HCU_MODE_S1, sess.s1_384, `HCU_PH_FINAL};
            msg_size = sess.size1;
            if (hash_rdy) begin
               hash_en   = 1'b1;
               state_nxt = DONE;
            end
         end
         DONE: begin
            // Any hash command releases S1
            if (hash_rdy) begin
               resp_done      = 1'b1;
               m_buf_clr      = 1'b1;
               sess.s1_clr    = 1'b1;
               sess.size1_clr = 1'b1;
               state_nxt      = IDLE;
            end
         end
         default: state_nxt = IDLE;
      endcase
   end

endmodule

`default_nettype wire

/* hw/hash_cu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module hash_cu_top (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     clr_hash,
   input  wire                     ss_expire,
   // L3 command port
   input  wire                     cmd_en,
   input  hash_cu_pkg::cmd_op_t    cmd_op,
   input  hash_cu_pkg::xfer_size_t cmd_extend,
   input  hash_cu_pkg::xfer_size_t wr_size,
   output logic                    cmd_rdy,
   output logic                    wr_open,
   output logic                    rd_open,
   output logic                    resp_done,
   output hash_cu_pkg::resp_err_t  resp_err,
   output logic                    rcv_clr,
   // Hash engine and buffers
   input  wire                     hash_update,
   input  wire                     msg_update,
   input  wire                     h_buf_rdy,
   input  wire                     m_buf_rdy,
   input  wire                     hash_rdy,
   input  wire                     hash_done,
   output logic                    hash_finish,
   output logic                    h_buf_clr,
   output logic                    h_buf_en,
   output logic                    h_buf_wrm,
   output logic                    m_buf_en,
   output logic                    m_buf_clr,
   output hash_cu_pkg::hash_op_t   hash_op,
   output logic                    hash_en,
   output logic                    hash_clr,
   output hash_cu_pkg::msg_size_t  msg_size
);

   session_if sess ();

   logic                    cmd_take;
   hash_cu_pkg::cmd_idx_t   cmd_idx;
   logic                    cmd_384;
   logic                    cmd_is_read;
   hash_cu_pkg::xfer_size_t cmd_wr_size;
   hash_cu_pkg::resp_err_t  verdict;

   cmd_check u_cmd_check (
      .clk         (clk),
      .rst_n       (rst_n),
      .cmd_take    (cmd_take),
      .cmd_op      (cmd_op),
      .cmd_extend  (cmd_extend),
      .wr_size     (wr_size),
      .sess        (sess.chk),
      .cmd_idx     (cmd_idx),
      .cmd_384     (cmd_384),
      .cmd_is_read (cmd_is_read),
      .cmd_wr_size (cmd_wr_size),
      .verdict     (verdict)
   );

   session_regs u_session_regs (
      .clk         (clk),
      .rst_n       (rst_n),
      .sess        (sess.regs),
      .cmd_wr_size (cmd_wr_size),
      .cmd_384     (cmd_384)
   );

   hash_seq_fsm u_hash_seq_fsm (
      .clk         (clk),
      .rst_n       (rst_n),
      .clr_hash    (clr_hash),
      .ss_expire   (ss_expire),
      .cmd_en      (cmd_en),
      .cmd_idx     (cmd_idx),
      .cmd_384     (cmd_384),
      .cmd_is_read (cmd_is_read),
      .verdict     (verdict),
      .hash_update (hash_update),
      .msg_update  (msg_update),
      .h_buf_rdy   (h_buf_rdy),
      .m_buf_rdy   (m_buf_rdy),
      .hash_rdy    (hash_rdy),
      .hash_done   (hash_done),
      .sess        (sess.seq),
      .cmd_take    (cmd_take),
      .cmd_rdy     (cmd_rdy),
      .wr_open     (wr_open),
      .rd_open     (rd_open),
      .resp_done   (resp_done),
      .resp_err    (resp_err),
      .rcv_clr     (rcv_clr),
      .hash_finish (hash_finish),
      .h_buf_clr   (h_buf_clr),
      .h_buf_en    (h_buf_en),
      .h_buf_wrm   (h_buf_wrm),
      .m_buf_en    (m_buf_en),
      .m_buf_clr   (m_buf_clr),
      .hash_op     (hash_op),
      .hash_en     (hash_en),
      .hash_clr    (hash_clr),
      .msg_size    (msg_size)
   );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
   output logic clk,
   output logic rst_n
);

   // 100 ns period
   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

/* dv/tb_hash_cu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hash_cu_defs.svh"

module tb_hash_cu;

   logic                    clk;
   logic                    rst_n;
   logic                    clr_hash;
   logic                    ss_expire;
   logic                    cmd_en;
   hash_cu_pkg::cmd_op_t    cmd_op;
   hash_cu_pkg::xfer_size_t cmd_extend;
   hash_cu_pkg::xfer_size_t wr_size;
   logic                    hash_update;
   logic                    msg_update;
   logic                    h_buf_rdy;
   logic                    m_buf_rdy;
   logic                    hash_rdy;
   logic                    hash_done;
   logic                    cmd_rdy;
   logic                    wr_open;
   logic                    rd_open;
   logic                    resp_done;
   hash_cu_pkg::resp_err_t  resp_err;
   logic                    rcv_clr;
   logic                    hash_finish;
   logic                    h_buf_clr;
   logic                    h_buf_en;
   logic                    h_buf_wrm;
   logic                    m_buf_en;
   logic                    m_buf_clr;
   hash_cu_pkg::hash_op_t   hash_op;
   logic                    hash_en;
   logic                    hash_clr;
   hash_cu_pkg::msg_size_t  msg_size;

   // Expected values, written at rising edges and compared at falling edges
   hash_cu_pkg::resp_err_t  exp_resp_err;
   hash_cu_pkg::hash_op_t   exp_hash_op;
   hash_cu_pkg::msg_size_t  exp_msg_size;
   logic                    exp_final;
   logic                    exp_clear;
   logic                    wrm_win;
   int                      hash_en_cnt;
   int                      err_cnt;

   // Session model
   logic                    m_s0_vld;
   logic                    m_s1_vld;
   logic                    m_s0_384;
   hash_cu_pkg::msg_size_t  m_size0;

   logic [31:0]             rnd;
   logic [31:0]             rdy_rnd;

   tb_clk_gen u_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   hash_cu_top u_hash_cu_top (
      .clk(clk), .rst_n(rst_n), .clr_hash(clr_hash), .ss_expire(ss_expire),
      .cmd_en(cmd_en), .cmd_op(cmd_op), .cmd_extend(cmd_extend), .wr_size(wr_size),
      .cmd_rdy(cmd_rdy), .wr_open(wr_open), .rd_open(rd_open), .resp_done(resp_done),
      .resp_err(resp_err), .rcv_clr(rcv_clr), .hash_update(hash_update),
      .msg_update(msg_update), .h_buf_rdy(h_buf_rdy), .m_buf_rdy(m_buf_rdy),
      .hash_rdy(hash_rdy), .hash_done(hash_done), .hash_finish(hash_finish),
      .h_buf_clr(h_buf_clr), .h_buf_en(h_buf_en), .h_buf_wrm(h_buf_wrm),
      .m_buf_en(m_buf_en), .m_buf_clr(m_buf_clr), .hash_op(hash_op), .hash_en(hash_en),
      .hash_clr(hash_clr), .msg_size(msg_size)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic hash_cu_pkg::hash_op_t make_hash_op(input logic [1:0] mode,
                                                          input logic is384,
                                                          input logic [1:0] phase);
      return {mode, is384, phase};
   endfunction

   // Expected response code from the command rules and the session model
   function automatic hash_cu_pkg::resp_err_t ref_verdict(input hash_cu_pkg::cmd_op_t op,
                                                         input hash_cu_pkg::xfer_size_t ext,
                                                         input hash_cu_pkg::xfer_size_t size);
      if (op == `HCU_CMD_READ) begin
         if (size != 0 || ext == 0 || ext > `HCU_RD_MAX) return `HCU_ERR_SIZE;
         return `HCU_ERR_NONE;
      end
      if (op[7:5] != 3'd0) return `HCU_ERR_CMD;
      case (op[3:0])
         `HCU_IDX_CLEAR: return `HCU_ERR_NONE;
         `HCU_IDX_S0_INIT: begin
            if (m_s1_vld) return `HCU_ERR_PRM;
            if (size != 0) return `HCU_ERR_SIZE;
            return `HCU_ERR_NONE;
         end
         `HCU_IDX_S0_RECV: begin
            if (!m_s0_vld || m_s1_vld) return `HCU_ERR_PRM;
            if (size == 0) return `HCU_ERR_SIZE;
            return `HCU_ERR_NONE;
         end
         `HCU_IDX_S0_FINL: begin
            if (!m_s0_vld || m_s1_vld) return `HCU_ERR_PRM;
            if (size != 0) return `HCU_ERR_SIZE;
            return `HCU_ERR_NONE;
         end
         `HCU_IDX_S1_CERT: return m_s1_vld ? `HCU_ERR_PRM : `HCU_ERR_NONE;
         default: return `HCU_ERR_CMD;
      endcase
   endfunction

   task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
      if (act !== exp) begin
         err_cnt = err_cnt + 1;
         $display("Fail at %0t: %s = %0h, expected %0h", $time, name, act, exp);
      end
   endtask

   task automatic reset_model();
      m_s0_vld = 1'b0;
      m_s1_vld = 1'b0;
      m_s0_384 = 1'b0;
      m_size0  = '0;
   endtask

   // Returns at the accepting edge with cmd_en already dropped
   task automatic issue_cmd(input hash_cu_pkg::cmd_op_t op,
                            input hash_cu_pkg::xfer_size_t ext,
                            input hash_cu_pkg::xfer_size_t size);
      int n;
      n = 0;
      @(negedge clk);
      while (!cmd_rdy && n < 200) begin
         @(negedge clk);
         n = n + 1;
      end
      if (!cmd_rdy) begin
         err_cnt = err_cnt + 1;
         $display("Timeout at %0t: cmd_rdy never came back", $time);
      end
      @(posedge clk);
      cmd_en     <= 1'b1;
      cmd_op     <= op;
      cmd_extend <= ext;
      wr_size    <= size;
      @(posedge clk);
      cmd_en <= 1'b0;
   endtask

   task automatic wait_resp_done();
      int n;
      n = 0;
      @(negedge clk);
      while (!resp_done && n < 300) begin
         @(negedge clk);
         n = n + 1;
      end
      if (!resp_done) begin
         err_cnt = err_cnt + 1;
         $display("Timeout at %0t: resp_done never pulsed", $time);
      end
   endtask

   // Commands that end after EXEC: errors, reads and the clear command
   task automatic short_cmd(input hash_cu_pkg::cmd_op_t op,
                            input hash_cu_pkg::xfer_size_t ext,
                            input hash_cu_pkg::xfer_size_t size);
      logic read_ok;
      @(posedge clk);
      exp_resp_err = ref_verdict(op, ext, size);
      exp_clear    = (op[7:5] == 3'd0) && (op[3:0] == `HCU_IDX_CLEAR);
      read_ok      = (op == `HCU_CMD_READ) && (exp_resp_err == `HCU_ERR_NONE);
      issue_cmd(op, ext, size);
      @(negedge clk);
      check_val("cmd_rdy", 32'(cmd_rdy), 32'd0);
      check_val("rd_open", 32'(rd_open), 32'(read_ok));
      check_val("resp_done", 32'(resp_done), 32'd0);
      @(negedge clk);
      // Only a legal read is back in IDLE here
      check_val("cmd_rdy", 32'(cmd_rdy), 32'(read_ok));
      check_val("resp_done", 32'(resp_done), 32'(!read_ok));
      if (exp_clear) begin
         reset_model();
      end
      @(posedge clk);
      exp_clear = 1'b0;
   endtask

   // S0 init, receive, final and the S1 certificate
   task automatic hash_cmd(input hash_cu_pkg::cmd_op_t op,
                           input hash_cu_pkg::xfer_size_t size,
                           input int n_upd);
      hash_cu_pkg::cmd_idx_t idx;
      logic                  b;
      int                    exp_cnt;
      int                    i;
      idx = op[3:0];
      b   = op[4];
      @(posedge clk);
      exp_resp_err = ref_verdict(op, '0, size);
      if (exp_resp_err != `HCU_ERR_NONE) begin
         err_cnt = err_cnt + 1;
         $display("Hash command %0h at %0t is not legal in this session state", op, $time);
      end
      exp_clear    = 1'b0;
      exp_final    = 1'b0;
      hash_en_cnt  = 0;
      h_buf_rdy   <= 1'b0;
      m_buf_rdy   <= 1'b0;
      case (idx)
         `HCU_IDX_S0_INIT: begin
            exp_hash_op = make_hash_op(`HCU_MODE_S0, b, `HCU_PH_INIT);
            exp_cnt     = n_upd + 1;
         end
         `HCU_IDX_S0_RECV: begin
            exp_hash_op = make_hash_op(`HCU_MODE_S0, m_s0_384, `HCU_PH_UPDATE);
            exp_cnt     = n_upd;
         end
         `HCU_IDX_S0_FINL: begin
            exp_hash_op  = make_hash_op(`HCU_MODE_S0, m_s0_384, `HCU_PH_FINAL);
            exp_final    = 1'b1;
            exp_msg_size = m_size0;
            exp_cnt      = 1;
         end
         default: begin
            exp_hash_op = make_hash_op(`HCU_MODE_S1, b, `HCU_PH_INIT);
            exp_cnt     = n_upd + 2;
         end
      endcase
      issue_cmd(op, '0, size);
      // First cycle after acceptance
      @(negedge clk);
      check_val("wr_open", 32'(wr_open),
                32'(idx == `HCU_IDX_S0_RECV || idx == `HCU_IDX_S1_CERT));
      check_val("h_buf_en", 32'(h_buf_en), 32'(idx == `HCU_IDX_S0_RECV));
      check_val("m_buf_en", 32'(m_buf_en), 32'(idx == `HCU_IDX_S1_CERT));
      check_val("hash_finish", 32'(hash_finish), 32'(idx == `HCU_IDX_S0_FINL));
      @(posedge clk);
      if (idx == `HCU_IDX_S0_INIT) begin
         exp_hash_op = make_hash_op(`HCU_MODE_S0, b, `HCU_PH_UPDATE);
      end else if (idx == `HCU_IDX_S1_CERT) begin
         exp_hash_op = make_hash_op(`HCU_MODE_S1, b, `HCU_PH_UPDATE);
      end
      wrm_win = (idx == `HCU_IDX_S0_INIT) || (idx == `HCU_IDX_S0_RECV);
      // Engine model, one update pulse per block
      for (i = 0; i < n_upd; i++) begin
         @(posedge clk);
         if (idx == `HCU_IDX_S1_CERT) begin
            msg_update <= 1'b1;
         end else begin
            hash_update <= 1'b1;
         end
         hash_done <= 1'b1;
         @(posedge clk);
         msg_update  <= 1'b0;
         hash_update <= 1'b0;
         hash_done   <= 1'b0;
      end
      wrm_win = 1'b0;
      if (idx == `HCU_IDX_S1_CERT) begin
         exp_hash_op  = make_hash_op(`HCU_MODE_S1, b, `HCU_PH_FINAL);
         exp_final    = 1'b1;
         exp_msg_size = hash_cu_pkg::msg_size_t'(size);
         m_buf_rdy   <= 1'b1;
      end else begin
         h_buf_rdy <= 1'b1;
      end
      wait_resp_done();
      @(posedge clk);
      check_val("hash_en count", 32'(hash_en_cnt), 32'(exp_cnt));
      exp_final = 1'b0;
      if (idx == `HCU_IDX_S0_INIT) begin
         m_s0_vld = 1'b1;
         m_s0_384 = b;
         m_size0  = '0;
      end else if (idx == `HCU_IDX_S0_RECV) begin
         m_size0 = m_size0 + hash_cu_pkg::msg_size_t'(size);
      end
      // DONE always releases S1
      m_s1_vld = 1'b0;
   endtask

   // S0 receive that is cut short by clr_hash or ss_expire
   task automatic clear_mid_hash(input hash_cu_pkg::xfer_size_t size,
                                 input logic by_expire);
      @(posedge clk);
      exp_resp_err = `HCU_ERR_NONE;
      exp_hash_op  = make_hash_op(`HCU_MODE_S0, m_s0_384, `HCU_PH_UPDATE);
      h_buf_rdy   <= 1'b0;
      issue_cmd(8'h02, '0, size);
      wrm_win = 1'b1;
      repeat (2) begin
         @(posedge clk);
         hash_update <= 1'b1;
         hash_done   <= 1'b1;
         @(posedge clk);
         hash_update <= 1'b0;
         hash_done   <= 1'b0;
      end
      wrm_win = 1'b0;
      @(posedge clk);
      exp_clear = 1'b1;
      if (by_expire) begin
         ss_expire <= 1'b1;
      end else begin
         clr_hash <= 1'b1;
      end
      @(posedge clk);
      clr_hash  <= 1'b0;
      ss_expire <= 1'b0;
      wait_resp_done();
      @(posedge clk);
      exp_clear = 1'b0;
      h_buf_rdy <= 1'b1;
      reset_model();
   endtask

   // Compare process
   always @(negedge clk) begin
      if (rst_n) begin
         // Digest writeback only in the S0 data phase
         check_val("h_buf_wrm", 32'(h_buf_wrm), 32'(hash_done && wrm_win));
         if (hash_en) begin
            hash_en_cnt = hash_en_cnt + 1;
            check_val("hash_op", 32'(hash_op), 32'(exp_hash_op));
            if (exp_final) begin
               check_val("msg_size", msg_size, exp_msg_size);
            end
         end
         if (resp_done) begin
            check_val("resp_err", 32'(resp_err), 32'(exp_resp_err));
            if (exp_clear) begin
               check_val("hash_clr", 32'(hash_clr), 32'd1);
               check_val("h_buf_clr", 32'(h_buf_clr), 32'd1);
               check_val("m_buf_clr", 32'(m_buf_clr), 32'd1);
               check_val("rcv_clr", 32'(rcv_clr), 32'd1);
            end
         end
      end
   end

   // hash_rdy drops at random
   always @(posedge clk) begin
      if (rst_n) begin
         rdy_rnd = xorshift(rdy_rnd);
         hash_rdy <= (rdy_rnd[1:0] != 2'b00);
      end
   end

   initial begin
      hash_cu_pkg::cmd_op_t op;
      int                   i;
      int                   n;
      clr_hash     = 1'b0;
      ss_expire    = 1'b0;
      cmd_en       = 1'b0;
      cmd_op       = '0;
      cmd_extend   = '0;
      wr_size      = '0;
      hash_update  = 1'b0;
      msg_update   = 1'b0;
      h_buf_rdy    = 1'b1;
      m_buf_rdy    = 1'b0;
      hash_rdy     = 1'b1;
      hash_done    = 1'b0;
      exp_resp_err = '0;
      exp_hash_op  = '0;
      exp_msg_size = '0;
      exp_final    = 1'b0;
      exp_clear    = 1'b0;
      wrm_win      = 1'b0;
      hash_en_cnt  = 0;
      err_cnt      = 0;
      rnd          = 32'h8905_c2bf;
      rdy_rnd      = xorshift(32'h8905_c2bf);
      reset_model();

      n = 0;
      while (!rst_n && n < 50) begin
         @(posedge clk);
         n = n + 1;
      end
      if (!rst_n) begin
         err_cnt = err_cnt + 1;
         $display("Reset was never released");
      end

      // Unknown opcodes, then indices 5 to 15
      for (i = 0; i < 6; i++) begin
         rnd = xorshift(rnd);
         op  = rnd[7:0];
         if (op[7:5] == 3'd0) op = op | 8'h20;
         if (op == `HCU_CMD_READ) op = 8'ha0;
         short_cmd(op, rnd[23:8], 16'(rnd[31:28]));
      end
      for (i = 5; i < 16; i++) begin
         rnd = xorshift(rnd);
         short_cmd({3'b000, rnd[0], 4'(i)}, '0, '0);
      end

      // Reads with legal and illegal sizes
      for (i = 0; i < 12; i++) begin
         rnd = xorshift(rnd);
         short_cmd(`HCU_CMD_READ, 16'(rnd[5:0]), (rnd[9:7] == 3'd0) ? 16'(rnd[13:10]) : 16'd0);
      end

      // Commands before any session exists
      short_cmd(8'h02, '0, 16'd16);
      short_cmd(8'h03, '0, '0);
      short_cmd(`HCU_CMD_READ, '0, '0);

      // S0 sequence with wrong sizes in between
      rnd = xorshift(rnd);
      hash_cmd({3'b000, rnd[0], 4'd1}, '0, 0);
      for (i = 0; i < 3; i++) begin
         rnd = xorshift(rnd);
         hash_cmd(8'h02, 16'(rnd[9:0]) + 16'd1, int'(rnd[13:12]));
      end
      short_cmd(8'h03, '0, 16'd8);
      short_cmd(8'h02, '0, '0);
      short_cmd(8'h01, '0, 16'd4);
      hash_cmd(8'h03, '0, 0);

      // Two certificates in a row
      for (i = 0; i < 2; i++) begin
         rnd = xorshift(rnd);
         hash_cmd({3'b000, rnd[0], 4'd4}, 16'(rnd[11:1]) + 16'd1, int'(rnd[14:13]));
      end

      // Clear command, then forced clear in the middle of a receive
      short_cmd(8'h00, '0, '0);
      short_cmd(8'h02, '0, 16'd16);
      hash_cmd(8'h11, '0, 1);
      rnd = xorshift(rnd);
      clear_mid_hash(16'(rnd[7:0]) + 16'd1, 1'b0);
      short_cmd(8'h02, '0, 16'd16);

      // Session expiry in the middle of a receive
      hash_cmd(8'h01, '0, 0);
      rnd = xorshift(rnd);
      clear_mid_hash(16'(rnd[7:0]) + 16'd1, 1'b1);
      short_cmd(8'h02, '0, 16'd16);

      repeat (5) @(posedge clk);
      $display("Checks done, %0d errors counted", err_cnt);
      if (err_cnt == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
hw/hash_cu_pkg.sv
hw/session_if.sv
hw/cmd_check.sv
hw/session_regs.sv
hw/hash_seq_fsm.sv
hw/hash_cu_top.sv
dv/tb_clk_gen.sv
dv/tb_hash_cu.sv

/* run.sh */
#!/bin/sh
# Build and run the hash sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_hash_cu -o sim_hash_cu
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_hash_cu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
   exit 0
fi
exit 1
